// ==== Makefile ====
SIM      = verilator
TOP      = mmio_bridge_tb
RTL_TOP  = mmio_bridge_top
FILELIST = tb.f
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing --assert -Wall
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/mmio_bridge_tb.sv ====
// ==========================================================
// Testbench for the MMIO to Avalon bridge. Drives host
// requests, models an Avalon memory sink with random
// waitrequest and read latency, and checks with assertions.
// ==========================================================

`timescale 1ns/100ps

module mmio_bridge_tb
    import mmio_bridge_pkg::*;
();

    localparam int DW      = 64;
    localparam int ADDR_W  = 16;
    localparam int MAX_OUT = 8;
    localparam int WORDS   = 2 ** ADDR_W;

    logic                clk;
    logic                rst;
    logic                req_valid;
    logic                req_ready;
    t_mmio_op            req_op;
    t_host_addr          req_addr;
    t_byte_count         req_byte_count;
    t_mmio_tag           req_tag;
    logic [DW-1:0]       req_payload;
    logic                mmio_read;
    logic                mmio_write;
    logic [ADDR_W-1:0]   mmio_address;
    logic [DW-1:0]       mmio_writedata;
    logic [DW/8-1:0]     mmio_byteenable;
    logic                mmio_waitrequest = 1'b0;
    logic [DW-1:0]       mmio_readdata = '0;
    logic                mmio_readdatavalid = 1'b0;
    logic                rsp_valid;
    logic                rsp_ready = 1'b1;
    t_mmio_tag           rsp_tag;
    logic [DW-1:0]       rsp_payload;

    // Sink memory, host-side shadow and the two in-order queues
    logic [DW-1:0]       sink_mem [WORDS];
    logic [DW-1:0]       shadow_mem [WORDS];
    logic [95:0]         pend_q [$];
    logic [73:0]         sb_q [$];

    int                  cycle = 0;
    int                  outstanding = 0;
    int                  err_count = 0;
    int                  err_mark = 0;
    int                  tests_run = 0;
    bit                  timed_out = 1'b0;
    bit                  wait_rand = 1'b0;
    int                  rsp_mode = 0;
    string               test_name = "none";
    bit                  exp_valid = 1'b0;
    t_mmio_tag           exp_tag = '0;
    logic [DW-1:0]       exp_data = '0;
    logic [7:0]          exp_be = '0;
    logic [DW-1:0]       exp_wd = '0;
    logic [ADDR_W-1:0]   exp_addr = '0;
    bit                  exp_wr_issue = 1'b0;

    mmio_bridge_top dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every field depends on the full word address
    function automatic logic [DW-1:0] fill_word(input int unsigned a);
        return {a[15:0] ^ 16'h5a5a, ~a[15:0], a[15:0] + 16'h3c3c, a[15:0]};
    endfunction

    // ==========================================================
    // Bookkeeping and Avalon sink model
    // ==========================================================

    always @(posedge clk)
    begin
        logic [ADDR_W-1:0] w;
        int                off;
        int                lat;
        logic [DW-1:0]     rd_word;
        cycle++;
        if (!rst)
        begin
            if (req_valid && req_ready)
            begin
                w   = req_addr[18:3];
                off = int'(req_addr[2:0]);
                if (req_op == MMIO_OP_READ)
                begin
                    // Addressed dword lands in the low bits
                    rd_word = shadow_mem[w];
                    if (req_addr[2])
                        rd_word = rd_word >> 32;
                    sb_q.push_back({req_tag, rd_word});
                    outstanding++;
                end
                else if (int'(req_byte_count) <= 8)
                begin
                    for (int i = 0; i < 8; i++)
                        if (i >= off && i < off + int'(req_byte_count))
                            shadow_mem[w][8*i +: 8] = req_payload[8*(i-off) +: 8];
                end
            end
            if (rsp_valid && rsp_ready && sb_q.size() > 0)
            begin
                void'(sb_q.pop_front());
                outstanding--;
            end
            if (mmio_write && !mmio_waitrequest)
                for (int b = 0; b < 8; b++)
                    if (mmio_byteenable[b])
                        sink_mem[mmio_address][8*b +: 8] = mmio_writedata[8*b +: 8];
            if (mmio_read && !mmio_waitrequest)
            begin
                lat = $urandom_range(1, 3);
                pend_q.push_back({32'(cycle + lat), sink_mem[mmio_address]});
            end
        end
    end

    // Sink outputs and rsp_ready change on the falling edge
    always @(negedge clk)
    begin
        mmio_waitrequest = wait_rand && ($urandom_range(0, 3) == 0);
        case (rsp_mode)
            0:       rsp_ready = 1'b1;
            1:       rsp_ready = 1'b0;
            default: rsp_ready = 1'($urandom_range(0, 1));
        endcase
        if (pend_q.size() > 0 && int'(pend_q[0][95:64]) <= cycle + 1)
        begin
            mmio_readdatavalid = 1'b1;
            mmio_readdata      = pend_q[0][63:0];
            void'(pend_q.pop_front());
        end
        else
        begin
            mmio_readdatavalid = 1'b0;
            mmio_readdata      = '0;
        end
        exp_valid = (sb_q.size() > 0);
        if (exp_valid)
            {exp_tag, exp_data} = sb_q[0];
    end

    // ==========================================================
    // Checks
    // ==========================================================

    task automatic log_error(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    a_reset_quiet: assert property (@(posedge clk)
        (cycle > 0 && (rst || $past(rst))) |-> (!rsp_valid && !mmio_read && !mmio_write))
        else log_error($sformatf("Error in %s: output active around reset", test_name));

    a_rsp_match: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready) |->
            (exp_valid && rsp_tag == exp_tag && rsp_payload == exp_data))
        else log_error($sformatf("Fail %s: expected tag %h data %h, actual tag %h data %h",
            test_name, exp_tag, exp_data, $sampled(rsp_tag), $sampled(rsp_payload)));

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_tag) && $stable(rsp_payload)))
        else log_error($sformatf("Error in %s: response changed while stalled", test_name));

    a_wr_issue: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_ready && req_op == MMIO_OP_WRITE) |-> (mmio_write == exp_wr_issue))
        else log_error($sformatf("Fail %s: expected mmio_write %b, actual %b",
            test_name, exp_wr_issue, $sampled(mmio_write)));

    a_wr_fields: assert property (@(posedge clk) disable iff (rst)
        mmio_write |-> (mmio_byteenable == exp_be && mmio_writedata == exp_wd))
        else log_error($sformatf("Fail %s: expected be %h data %h, actual be %h data %h",
            test_name, exp_be, exp_wd, $sampled(mmio_byteenable), $sampled(mmio_writedata)));

    // Bus word address of every issued access
    a_addr_map: assert property (@(posedge clk) disable iff (rst)
        (mmio_read || mmio_write) |-> (mmio_address == exp_addr))
        else log_error($sformatf("Fail %s: expected address %h, actual %h",
            test_name, exp_addr, $sampled(mmio_address)));

    // Ready drops exactly when the read window is full
    a_ready_level: assert property (@(posedge clk) disable iff (rst)
        !mmio_waitrequest |-> (req_ready == (outstanding < MAX_OUT)))
        else log_error($sformatf("Fail %s: expected req_ready %b, actual %b",
            test_name, $sampled(outstanding) < MAX_OUT, $sampled(req_ready)));

    a_no_read_blocked: assert property (@(posedge clk) disable iff (rst)
        !req_ready |-> !mmio_read)
        else log_error($sformatf("Error in %s: read issued while req_ready low", test_name));

    // ==========================================================
    // Stimulus
    // ==========================================================

    task automatic report_timeout(input string what);
        log_error($sformatf("Timeout in %s: %s did not happen in time", test_name, what));
        timed_out = 1'b1;
    endtask

    task automatic try_req(input t_mmio_op op, input t_host_addr addr, input t_byte_count bc,
                           input t_mmio_tag tag, input logic [DW-1:0] payload,
                           input int max_cycles, output bit accepted);
        int off;
        accepted = 1'b0;
        off      = int'(addr[2:0]);
        @(negedge clk);
        req_valid      = 1'b1;
        req_op         = op;
        req_addr       = addr;
        req_byte_count = bc;
        req_tag        = tag;
        req_payload    = payload;
        exp_wr_issue   = (int'(bc) <= 8);
        exp_wd         = payload << (8 * off);
        exp_addr       = ADDR_W'(addr / (DW / 8));
        for (int b = 0; b < 8; b++)
            exp_be[b] = (b >= off) && (b < off + int'(bc));
        for (int n = 0; n < max_cycles && !accepted; n++)
        begin
            @(posedge clk);
            accepted = req_ready;
        end
    endtask

    task automatic send_req(input t_mmio_op op, input t_host_addr addr, input t_byte_count bc,
                            input t_mmio_tag tag, input logic [DW-1:0] payload);
        bit ok;
        if (timed_out)
            return;
        try_req(op, addr, bc, tag, payload, 200, ok);
        if (!ok)
            report_timeout("request acceptance");
    endtask

    task automatic drop_valid();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic set_modes(input bit wr_rand, input int rsp_sel);
        @(posedge clk);
        wait_rand = wr_rand;
        rsp_mode  = rsp_sel;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        drop_valid();
        while (!timed_out && sb_q.size() > 0)
        begin
            @(negedge clk);
            n++;
            if (n > 500)
                report_timeout("read response drain");
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = err_count;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %s done, %0d new errors", test_name, err_count - err_mark);
    endtask

    initial
    begin
        bit         ok;
        t_mmio_op   op;
        t_host_addr addr;
        void'($urandom(32'hd3a1_b1b3));
        rst            = 1'b1;
        req_valid      = 1'b0;
        req_op         = MMIO_OP_READ;
        req_addr       = '0;
        req_byte_count = '0;
        req_tag        = '0;
        req_payload    = '0;
        for (int a = 0; a < WORDS; a++)
        begin
            sink_mem[16'(a)]   = fill_word(a);
            shadow_mem[16'(a)] = fill_word(a);
        end

        start_test("reset_state");
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        finish_test();

        start_test("full_write_read");
        send_req(MMIO_OP_WRITE, 32'h40, 7'd8, 10'h011, 64'h0123_4567_89ab_cdef);
        send_req(MMIO_OP_READ, 32'h40, 7'd8, 10'h012, '0);
        wait_drain();
        finish_test();

        start_test("partial_write_dword_read");
        send_req(MMIO_OP_WRITE, 32'h84, 7'd4, 10'h021, 64'h0000_0000_cafe_f00d);
        send_req(MMIO_OP_READ, 32'h84, 7'd4, 10'h022, '0);
        wait_drain();
        finish_test();

        start_test("oversize_write_dropped");
        send_req(MMIO_OP_WRITE, 32'hc0, 7'd16, 10'h031, 64'hdead_beef_dead_beef);
        send_req(MMIO_OP_READ, 32'hc0, 7'd8, 10'h032, '0);
        wait_drain();
        finish_test();

        // Fill the read window with rsp_ready low, then release
        start_test("backpressure_order");
        set_modes(1'b0, 1);
        for (int i = 0; i < MAX_OUT + 2; i++)
        begin
            try_req(MMIO_OP_READ, 32'(256 + 12 * i), 7'd4, t_mmio_tag'(10'h100 + i), '0, 6, ok);
            if (!ok)
                break;
        end
        drop_valid();
        set_modes(1'b0, 0);
        wait_drain();
        finish_test();

        start_test("random_traffic");
        set_modes(1'b1, 2);
        for (int i = 0; i < 200; i++)
        begin
            op   = t_mmio_op'($urandom_range(0, 1));
            addr = t_host_addr'($urandom_range(0, 511));
            send_req(op, addr, t_byte_count'($urandom_range(1, 10)), t_mmio_tag'(i),
                     {$urandom(), $urandom()});
        end
        wait_drain();
        finish_test();

        $display("Tests run: %0d, errors: %0d", tests_run, err_count);
        if (err_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/mmio_bridge_pkg.sv
verilog/mmio_rd_meta_if.sv
verilog/mmio_req_dispatch.sv
verilog/mmio_rd_meta_fifo.sv
verilog/mmio_rsp_assembler.sv
verilog/mmio_bridge_top.sv
dv/mmio_bridge_tb.sv

// ==== verilog/mmio_bridge_pkg.sv ====
// ==========================================================
// Shared types and constants for the MMIO to Avalon bridge.
// Modules pull these in with a wildcard import in their
// header; bus widths stay module parameters.
// ==========================================================

package mmio_bridge_pkg;

    // ==========================================================
    // Fixed widths
    // ==========================================================

    // Smallest addressable unit on the host side
    localparam int DWORD_WIDTH = 32;

    localparam int HOST_ADDR_WIDTH = 32;
    localparam int TAG_WIDTH = 10;

    // Wide enough to express an oversize write of up to 64 bytes
    localparam int BYTE_COUNT_WIDTH = 7;

    // Upper bound for the Avalon data width
    localparam int MAX_DATA_WIDTH = 512;

    // ==========================================================
    // Request fields
    // ==========================================================

    typedef enum logic [0:0]
    {
        MMIO_OP_READ  = 1'b0,
        MMIO_OP_WRITE = 1'b1
    } t_mmio_op;

    typedef logic [HOST_ADDR_WIDTH-1:0] t_host_addr;

    typedef logic [TAG_WIDTH-1:0] t_mmio_tag;

    typedef logic [BYTE_COUNT_WIDTH-1:0] t_byte_count;

endpackage

// ==== verilog/mmio_bridge_top.sv ====
// ==========================================================
// MMIO bridge top level. Host requests enter on plain ports,
// leave as Avalon reads and writes, and read data comes back
// to the host in request order with its tag.
// ==========================================================

`timescale 1ns/100ps

module mmio_bridge_top
    import mmio_bridge_pkg::*;
#(
    parameter int MMIO_DATA_WIDTH    = 64,
    parameter int MMIO_ADDR_WIDTH    = 16,
    parameter int MAX_OUTSTANDING_RD = 8
)
(
    input  logic                         clk,
    input  logic                         rst,

    // Host requests
    input  logic                         req_valid,
    output logic                         req_ready,
    input  t_mmio_op                     req_op,
    input  t_host_addr                   req_addr,
    input  t_byte_count                  req_byte_count,
    input  t_mmio_tag                    req_tag,
    input  logic [MMIO_DATA_WIDTH-1:0]   req_payload,

    // Avalon sink
    output logic                         mmio_read,
    output logic                         mmio_write,
    output logic [MMIO_ADDR_WIDTH-1:0]   mmio_address,
    output logic [MMIO_DATA_WIDTH-1:0]   mmio_writedata,
    output logic [MMIO_DATA_WIDTH/8-1:0] mmio_byteenable,
    input  logic                         mmio_waitrequest,
    input  logic [MMIO_DATA_WIDTH-1:0]   mmio_readdata,
    input  logic                         mmio_readdatavalid,

    // Host responses
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output t_mmio_tag                    rsp_tag,
    output logic [MMIO_DATA_WIDTH-1:0]   rsp_payload
);

    mmio_rd_meta_if #(.MMIO_DATA_WIDTH(MMIO_DATA_WIDTH)) meta_if ();

    mmio_req_dispatch #(
        .MMIO_DATA_WIDTH (MMIO_DATA_WIDTH),
        .MMIO_ADDR_WIDTH (MMIO_ADDR_WIDTH)
    ) dispatch_i (
        .clk              (clk),
        .rst              (rst),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_op           (req_op),
        .req_addr         (req_addr),
        .req_byte_count   (req_byte_count),
        .req_tag          (req_tag),
        .req_payload      (req_payload),
        .mmio_read        (mmio_read),
        .mmio_write       (mmio_write),
        .mmio_address     (mmio_address),
        .mmio_writedata   (mmio_writedata),
        .mmio_byteenable  (mmio_byteenable),
        .mmio_waitrequest (mmio_waitrequest),
        .meta             (meta_if.dispatch)
    );

    // Depth here bounds the reads in flight
    mmio_rd_meta_fifo #(
        .MMIO_DATA_WIDTH    (MMIO_DATA_WIDTH),
        .MAX_OUTSTANDING_RD (MAX_OUTSTANDING_RD)
    ) meta_fifo_i (
        .clk  (clk),
        .rst  (rst),
        .meta (meta_if.fifo)
    );

    mmio_rsp_assembler #(
        .MMIO_DATA_WIDTH    (MMIO_DATA_WIDTH),
        .MAX_OUTSTANDING_RD (MAX_OUTSTANDING_RD)
    ) assembler_i (
        .clk                (clk),
        .rst                (rst),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .meta               (meta_if.assembler),
        .rsp_valid          (rsp_valid),
        .rsp_ready          (rsp_ready),
        .rsp_tag            (rsp_tag),
        .rsp_payload        (rsp_payload)
    );

endmodule

// ==== verilog/mmio_rd_meta_fifo.sv ====
// ==========================================================
// In-order FIFO of read metadata. Each entry holds the tag
// and dword index of one outstanding Avalon read. The depth
// sets how many reads may be in flight at once.
// ==========================================================

`timescale 1ns/100ps

module mmio_rd_meta_fifo
    import mmio_bridge_pkg::*;
#(
    parameter int MMIO_DATA_WIDTH    = 64,
    parameter int MAX_OUTSTANDING_RD = 8
)
(
    input  logic          clk,
    input  logic          rst,

    mmio_rd_meta_if.fifo  meta
);

    localparam int PTR_BITS = $clog2(MAX_OUTSTANDING_RD);
    localparam int DWORD_IDX_BITS = $clog2(MMIO_DATA_WIDTH / DWORD_WIDTH);

    // Tag and dword index storage
    t_mmio_tag                 tag_mem [MAX_OUTSTANDING_RD];
    logic [DWORD_IDX_BITS-1:0] idx_mem [MAX_OUTSTANDING_RD];

    logic [PTR_BITS-1:0]       wr_ptr;
    logic [PTR_BITS-1:0]       rd_ptr;
    logic [PTR_BITS:0]         count;

    always_ff @(posedge clk)
    begin
        if (meta.enq_en)
        begin
            tag_mem[wr_ptr] <= meta.enq_tag;
            idx_mem[wr_ptr] <= meta.enq_dword_idx;
        end
    end

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (meta.enq_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (meta.deq_en)
                rd_ptr <= rd_ptr + 1'b1;

            case ({meta.enq_en, meta.deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign meta.not_full  = (count != (PTR_BITS+1)'(MAX_OUTSTANDING_RD));
    assign meta.not_empty = (count != '0);

    assign meta.first_tag       = tag_mem[rd_ptr];
    assign meta.first_dword_idx = idx_mem[rd_ptr];

    a_no_deq_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        meta.deq_en |-> meta.not_empty
    );

endmodule

// ==== verilog/mmio_rd_meta_if.sv ====
// ==========================================================
// Read metadata channel. The dispatcher pushes the tag and
// dword index of each accepted read, the FIFO holds them in
// order and the response assembler pops them on handshake.
// ==========================================================

`timescale 1ns/100ps

interface mmio_rd_meta_if
    import mmio_bridge_pkg::*;
#(
    parameter int MMIO_DATA_WIDTH = 64
) ();

    // Dword index within one bus word
    localparam int DWORD_IDX_BITS = $clog2(MMIO_DATA_WIDTH / DWORD_WIDTH);

    // Enqueue side with a one-cycle strobe
    logic                      enq_en;
    t_mmio_tag                 enq_tag;
    logic [DWORD_IDX_BITS-1:0] enq_dword_idx;
    logic                      not_full;

    // Dequeue side with the head entry valid while not_empty
    logic                      deq_en;
    logic                      not_empty;
    t_mmio_tag                 first_tag;
    logic [DWORD_IDX_BITS-1:0] first_dword_idx;

    modport dispatch
    (
        output enq_en, enq_tag, enq_dword_idx,
        input  not_full
    );

    modport fifo
    (
        input  enq_en, enq_tag, enq_dword_idx, deq_en,
        output not_full, not_empty, first_tag, first_dword_idx
    );

    modport assembler
    (
        input  not_empty, first_tag, first_dword_idx,
        output deq_en
    );

endinterface

// ==== verilog/mmio_req_dispatch.sv ====
// ==========================================================
// Host request dispatcher. Turns each host read or write
// into an Avalon access with zero latency, aligns write data
// and byte enables to the bus word, and records read tags.
// ==========================================================

`timescale 1ns/100ps

module mmio_req_dispatch
    import mmio_bridge_pkg::*;
#(
    parameter int MMIO_DATA_WIDTH = 64,
    parameter int MMIO_ADDR_WIDTH = 16
)
(
    input  logic                         clk,
    input  logic                         rst,

    // Host requests
    input  logic                         req_valid,
    output logic                         req_ready,
    input  t_mmio_op                     req_op,
    input  t_host_addr                   req_addr,
    input  t_byte_count                  req_byte_count,
    input  t_mmio_tag                    req_tag,
    input  logic [MMIO_DATA_WIDTH-1:0]   req_payload,

    // Avalon request side
    output logic                         mmio_read,
    output logic                         mmio_write,
    output logic [MMIO_ADDR_WIDTH-1:0]   mmio_address,
    output logic [MMIO_DATA_WIDTH-1:0]   mmio_writedata,
    output logic [MMIO_DATA_WIDTH/8-1:0] mmio_byteenable,
    input  logic                         mmio_waitrequest,

    mmio_rd_meta_if.dispatch             meta
);

    localparam int BUS_BYTES = MMIO_DATA_WIDTH / 8;
    localparam int BYTE_IDX_BITS = $clog2(BUS_BYTES);
    localparam int DWORD_IDX_BITS = $clog2(MMIO_DATA_WIDTH / DWORD_WIDTH);
    localparam int DWORD_BYTE_BITS = $clog2(DWORD_WIDTH / 8);

    localparam bit WIDTH_LEGAL =
        (MMIO_DATA_WIDTH >= 64) && (MMIO_DATA_WIDTH <= MAX_DATA_WIDTH) &&
        (MMIO_DATA_WIDTH == (2 ** $clog2(MMIO_DATA_WIDTH)));

    logic                        req_fire;
    logic                        wr_fits;
    logic [BYTE_IDX_BITS-1:0]    byte_offset;
    logic [BYTE_IDX_BITS+2:0]    wr_shift;
    logic [BUS_BYTES-1:0]        be_base;

    // ==========================================================
    // Handshake and command decode
    // ==========================================================

    // Ready ignores the opcode, so a write also waits for FIFO space
    assign req_ready = !mmio_waitrequest && meta.not_full;
    assign req_fire  = req_valid && req_ready;

    // Oversize writes are accepted and dropped
    assign wr_fits = (req_byte_count <= t_byte_count'(BUS_BYTES));

    assign mmio_read  = req_fire && (req_op == MMIO_OP_READ);
    assign mmio_write = req_fire && (req_op == MMIO_OP_WRITE) && wr_fits;

    assign mmio_address = req_addr[BYTE_IDX_BITS +: MMIO_ADDR_WIDTH];

    // ==========================================================
    // Write data and byte enable alignment
    // ==========================================================

    assign byte_offset = req_addr[BYTE_IDX_BITS-1:0];
    assign wr_shift    = {byte_offset, 3'b000};

    always_comb
    begin
        be_base = '0;
        for (int i = 0; i < BUS_BYTES; i++)
        begin
            if (i < int'(req_byte_count))
            begin
                be_base[i] = 1'b1;
            end
        end
    end

    assign mmio_byteenable = be_base << byte_offset;
    assign mmio_writedata  = req_payload << wr_shift;

    // Read metadata is enqueued as the read is accepted
    assign meta.enq_en        = mmio_read;
    assign meta.enq_tag       = req_tag;
    assign meta.enq_dword_idx = req_addr[DWORD_BYTE_BITS +: DWORD_IDX_BITS];

    // ==========================================================
    // Assertions
    // ==========================================================

    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(mmio_read && mmio_write)
    );

    // The FIFO must have room at the cycle the read goes out
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        meta.enq_en |-> meta.not_full
    );

    a_width_legal: assert property (
        @(posedge clk)
        WIDTH_LEGAL
    );

endmodule

// ==== verilog/mmio_rsp_assembler.sv ====
// ==========================================================
// Read response assembler. Buffers Avalon read data, pairs
// each word with the head of the metadata FIFO and returns
// a registered response with the addressed dword at bit 0.
// ==========================================================

`timescale 1ns/100ps

module mmio_rsp_assembler
    import mmio_bridge_pkg::*;
#(
    parameter int MMIO_DATA_WIDTH    = 64,
    parameter int MAX_OUTSTANDING_RD = 8
)
(
    input  logic                       clk,
    input  logic                       rst,

    // Avalon read return without flow control
    input  logic [MMIO_DATA_WIDTH-1:0] mmio_readdata,
    input  logic                       mmio_readdatavalid,

    mmio_rd_meta_if.assembler          meta,

    // Host responses
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output t_mmio_tag                  rsp_tag,
    output logic [MMIO_DATA_WIDTH-1:0] rsp_payload
);

    localparam int PTR_BITS = $clog2(MAX_OUTSTANDING_RD);
    localparam int DWORD_BIT_BITS = $clog2(DWORD_WIDTH);

    logic [MMIO_DATA_WIDTH-1:0]       data_mem [MAX_OUTSTANDING_RD];
    logic [PTR_BITS-1:0]              data_wr_ptr;
    logic [PTR_BITS-1:0]              data_rd_ptr;
    logic [PTR_BITS:0]                data_count;
    logic                             data_not_empty;
    logic                             data_not_full;

    logic                             rsp_fire;
    logic                             rsp_load;
    logic [$clog2(MMIO_DATA_WIDTH)-1:0] rd_shift;

    // ==========================================================
    // Read data FIFO
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (mmio_readdatavalid)
            data_mem[data_wr_ptr] <= mmio_readdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            data_wr_ptr <= '0;
            data_rd_ptr <= '0;
            data_count  <= '0;
        end
        else
        begin
            if (mmio_readdatavalid)
                data_wr_ptr <= data_wr_ptr + 1'b1;
            if (rsp_fire)
                data_rd_ptr <= data_rd_ptr + 1'b1;

            case ({mmio_readdatavalid, rsp_fire})
                2'b10:   data_count <= data_count + 1'b1;
                2'b01:   data_count <= data_count - 1'b1;
                default: data_count <= data_count;
            endcase
        end
    end

    assign data_not_empty = (data_count != '0);
    assign data_not_full  = (data_count != (PTR_BITS+1)'(MAX_OUTSTANDING_RD));

    // ==========================================================
    // Output register
    // ==========================================================

    // Both heads stay in place until the host takes the response
    assign rsp_fire    = rsp_valid && rsp_ready;
    assign meta.deq_en = rsp_fire;

    assign rsp_load = !rsp_valid && data_not_empty && meta.not_empty;
    assign rd_shift = {meta.first_dword_idx, {DWORD_BIT_BITS{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (rst)
            rsp_valid <= 1'b0;
        else if (rsp_load)
            rsp_valid <= 1'b1;
        else if (rsp_fire)
            rsp_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rsp_load)
        begin
            rsp_tag     <= meta.first_tag;
            rsp_payload <= data_mem[data_rd_ptr] >> rd_shift;
        end
    end

    // ==========================================================
    // Assertions
    // ==========================================================

    // Every returned word must have a matching metadata slot
    a_no_data_overflow: assert property (
        @(posedge clk) disable iff (rst)
        mmio_readdatavalid |-> data_not_full
    );

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=>
            (rsp_valid && $stable(rsp_tag) && $stable(rsp_payload))
    );

endmodule
